/* filelist.f */
+incdir+source
source/ex_data_pkg.sv
source/ex_op_pkg.sv
source/ex_issue_reg.sv
source/ex_forward.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_multiplier.sv
source/ex_stage.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - source
    files:
      - source/ex_data_pkg.sv
      - source/ex_op_pkg.sv
      - source/ex_issue_reg.sv
      - source/ex_forward.sv
      - source/ex_alu.sv
      - source/ex_branch_unit.sv
      - source/ex_multiplier.sv
      - source/ex_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/ex_stage_checker.sv
      - tb/ex_stage_tb.sv

/* tb/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb
    import ex_data_pkg::*;
    import ex_op_pkg::*;
();

    localparam int WAIT_LIMIT = 400;

    // one expected output transfer
    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        xlen_t    result;
        logic     check_result;
        logic     redirect;
        addr_t    dnpc;
    } expect_t;

    logic     clk, rst, flush;
    logic     in_valid, in_ready, in_imm_sel;
    addr_t    in_pc;
    ex_op_t   in_op;
    br_cond_t in_cond;
    reg_idx_t in_rd, in_rs1, in_rs2;
    xlen_t    in_src_a, in_src_b, in_imm;
    logic     out_valid, out_ready;
    addr_t    out_pc;
    reg_idx_t out_rd;
    xlen_t    out_result;
    logic     mem_wen, wb_wen;
    reg_idx_t mem_rd, wb_rd;
    xlen_t    mem_data, wb_data;
    logic     pc_update;
    addr_t    dnpc;

    expect_t     exp_q[$];
    int          errors;
    int          checks;
    int          timeouts;
    logic [31:0] lfsr_state;
    logic        ready_random;
    addr_t       pc_next;

    ex_op_t   alu_ops [13] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
                               OP_SRA, OP_SLT, OP_SLTU, OP_ADDW, OP_LUI, OP_AUIPC};
    br_cond_t conds [6]    = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    // equal pair then mixed-sign pairs in both orders
    xlen_t    pair_a [3]   = '{64'd5, 64'hffff_ffff_ffff_fffd, 64'd7};
    xlen_t    pair_b [3]   = '{64'd5, 64'd7, 64'hffff_ffff_ffff_fffd};

    ex_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    // newest bit ends up in the lsb
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // MEM before WB before register file
    // x0 is never bypassed
    function automatic xlen_t fwd_value(input reg_idx_t idx, input xlen_t rf);
        if (idx == '0) return rf;
        if (mem_wen && (mem_rd == idx)) return mem_data;
        if (wb_wen && (wb_rd == idx)) return wb_data;
        return rf;
    endfunction

    function automatic expect_t ref_execute(input ex_op_t op, input br_cond_t cond,
            input logic imm_sel, input addr_t pc, input xlen_t a, input xlen_t b,
            input xlen_t imm);
        expect_t     e;
        xlen_t       rhs;
        xlen_t       sum;
        logic [31:0] word;
        logic        taken;
        rhs  = imm_sel ? imm : b;
        sum  = a + rhs;
        word = a[31:0] + rhs[31:0];
        e = '0;
        e.pc = pc;
        e.check_result = 1'b1;
        e.dnpc = pc + addr_t'(`EX_INST_BYTES);
        case (op)
            OP_ADD:   e.result = sum;
            OP_SUB:   e.result = a - rhs;
            OP_AND:   e.result = a & rhs;
            OP_OR:    e.result = a | rhs;
            OP_XOR:   e.result = a ^ rhs;
            OP_SLL:   e.result = a << rhs[5:0];
            OP_SRL:   e.result = a >> rhs[5:0];
            OP_SRA:   e.result = $signed(a) >>> rhs[5:0];
            OP_SLT:   e.result = {63'd0, $signed(a) < $signed(rhs)};
            OP_SLTU:  e.result = {63'd0, a < rhs};
            OP_ADDW:  e.result = xlen_t'($signed(word));
            OP_LUI:   e.result = imm;
            OP_AUIPC: e.result = pc + imm;
            // multiplier always takes both registers
            OP_MUL:   e.result = a * b;
            OP_JAL, OP_JALR: begin
                e.result   = pc + addr_t'(`EX_INST_BYTES);
                e.redirect = 1'b1;
                e.dnpc     = (op == OP_JAL) ? pc + imm : ((a + imm) & ~64'd1);
            end
            default: begin
                // branch result value is don't care
                e.check_result = 1'b0;
                case (cond)
                    BEQ:     taken = (a == b);
                    BNE:     taken = (a != b);
                    BLT:     taken = ($signed(a) < $signed(b));
                    BGE:     taken = ($signed(a) >= $signed(b));
                    BLTU:    taken = (a < b);
                    BGEU:    taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                e.redirect = taken;
                if (taken) e.dnpc = pc + imm;
            end
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic end_run();
        int total;
        total = errors + timeouts + u_dut.u_chk.fail_count;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, u_dut.u_chk.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        timeouts++;
        $display("timeout: %s at %0t", what, $time);
        end_run();
    endtask

    // about three cycles in four ready
    task automatic update_ready();
        if (ready_random) out_ready = (rand_bits(2) != 0);
    endtask

    // drive one instruction and hold it until the stage takes it
    task automatic issue(input ex_op_t op, input br_cond_t cond, input logic imm_sel,
            input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
            input xlen_t a, input xlen_t b, input xlen_t imm);
        expect_t e;
        int      waited;
        logic    accepted;
        e = ref_execute(op, cond, imm_sel, pc_next, fwd_value(rs1, a), fwd_value(rs2, b), imm);
        e.rd = rd;
        in_valid   = 1'b1;
        in_pc      = pc_next;
        in_op      = op;
        in_cond    = cond;
        in_imm_sel = imm_sel;
        in_rd      = rd;
        in_rs1     = rs1;
        in_rs2     = rs2;
        in_src_a   = a;
        in_src_b   = b;
        in_imm     = imm;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = in_ready;
            if (accepted) exp_q.push_back(e);
            @(negedge clk);
            update_ready();
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout("instruction never accepted");
        end
        in_valid = 1'b0;
        pc_next  = pc_next + addr_t'(`EX_INST_BYTES);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        if (!ready_random) out_ready = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            update_ready();
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout("stage did not drain");
        end
    endtask

    // bypass only changes with the stage empty
    task automatic set_bypass(input logic mw, input reg_idx_t mrd, input xlen_t md,
            input logic ww, input reg_idx_t wrd, input xlen_t wd);
        drain();
        mem_wen  = mw;
        mem_rd   = mrd;
        mem_data = md;
        wb_wen   = ww;
        wb_rd    = wrd;
        wb_data  = wd;
    endtask

    // nothing may enter while the product is pending
    task automatic wait_mul_out();
        int   waited;
        logic fired;
        waited = 0;
        fired  = 1'b0;
        while (!fired) begin
            @(posedge clk);
            fired = out_valid && out_ready;
            if (!fired) check_value("in_ready", 64'(in_ready), 64'd0);
            @(negedge clk);
            update_ready();
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout("multiplier result never left the stage");
        end
    endtask

    // in-order compare on each output transfer
    always @(posedge clk) begin : compare
        expect_t e;
        if (!rst) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output transfer with no instruction in flight at %0t", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("out_pc", out_pc, e.pc);
                    check_value("out_rd", 64'(out_rd), 64'(e.rd));
                    if (e.check_result) check_value("out_result", out_result, e.result);
                    check_value("pc_update", 64'(pc_update), 64'(e.redirect));
                    check_value("dnpc", dnpc, e.dnpc);
                end
            end else begin
                check_value("pc_update", 64'(pc_update), 64'd0);
            end
        end
    end

    initial begin
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm;
        logic [63:0] v;
        int          idx;
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        lfsr_state   = 32'hf48e298c;
        ready_random = 1'b0;
        pc_next      = 64'h8000_0000;
        rst        = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_op      = OP_ADD;
        in_cond    = BEQ;
        in_imm_sel = 1'b0;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_src_a   = '0;
        in_src_b   = '0;
        in_imm     = '0;
        out_ready  = 1'b0;
        mem_wen    = 1'b0;
        mem_rd     = '0;
        mem_data   = '0;
        wb_wen     = 1'b0;
        wb_rd      = '0;
        wb_data    = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // empty stage with downstream not ready
        repeat (4) begin
            @(posedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);
            check_value("pc_update", 64'(pc_update), 64'd0);
            check_value("in_ready", 64'(in_ready), 64'd0);
        end
        @(negedge clk);

        // random alu traffic with x3 from MEM and x5 from WB
        set_bypass(1'b1, 5'd3, rand_bits(64), 1'b1, 5'd5, rand_bits(64));
        ready_random = 1'b1;
        repeat (60) begin
            idx = int'(rand_bits(4)) % 13;
            a   = rand_bits(64);
            b   = rand_bits(64);
            imm = rand_bits(64);
            issue(alu_ops[idx], BEQ, 1'(rand_bits(1)), reg_idx_t'(rand_bits(5)),
                  reg_idx_t'(rand_bits(3)), reg_idx_t'(rand_bits(3)), a, b, imm);
        end

        // bypass priority of MEM over WB over register file
        ready_random = 1'b0;
        set_bypass(1'b1, 5'd4, 64'h1111, 1'b1, 5'd4, 64'h2222);
        issue(OP_ADD, BEQ, 1'b0, 5'd1, 5'd4, 5'd6, 64'h10, 64'h20, 64'd0);
        set_bypass(1'b0, 5'd4, 64'h1111, 1'b1, 5'd4, 64'h2222);
        issue(OP_ADD, BEQ, 1'b0, 5'd2, 5'd4, 5'd6, 64'h10, 64'h20, 64'd0);
        set_bypass(1'b1, 5'd6, 64'h3333, 1'b1, 5'd4, 64'h4444);
        issue(OP_SUB, BEQ, 1'b0, 5'd3, 5'd4, 5'd6, 64'h10, 64'h20, 64'd0);
        // x0 stays on the register value
        set_bypass(1'b1, 5'd0, 64'h5555, 1'b1, 5'd0, 64'h6666);
        issue(OP_OR, BEQ, 1'b0, 5'd4, 5'd0, 5'd0, 64'h10, 64'h20, 64'd0);

        // every condition on three operand pairs followed by both jumps
        set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 5'd0, 64'd0);
        ready_random = 1'b1;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                v   = rand_bits(12);
                imm = {{52{v[11]}}, v[11:1], 1'b0};
                issue(OP_BRANCH, conds[c], 1'b0, 5'd0, 5'd1, 5'd2, pair_a[p], pair_b[p], imm);
            end
        end
        issue(OP_JAL, BEQ, 1'b1, 5'd1, 5'd0, 5'd0, 64'd0, 64'd0, 64'h40);
        // odd jalr sum loses bit 0
        issue(OP_JALR, BEQ, 1'b1, 5'd1, 5'd3, 5'd0, 64'h8000_1235, 64'd0, 64'h10);

        // multiplies each followed by a plain op
        repeat (6) begin
            a = rand_bits(64);
            b = rand_bits(64);
            issue(OP_MUL, BEQ, 1'b0, reg_idx_t'(rand_bits(5)), 5'd1, 5'd2, a, b, 64'd0);
            wait_mul_out();
            issue(OP_XOR, BEQ, 1'b0, 5'd9, 5'd1, 5'd2, rand_bits(64), rand_bits(64), 64'd0);
        end
        issue(OP_MUL, BEQ, 1'b0, 5'd10, 5'd1, 5'd2, '1, 64'd3, 64'd0);
        wait_mul_out();

        // flush an alu op stalled by back-pressure
        ready_random = 1'b0;
        drain();
        issue(OP_ADD, BEQ, 1'b0, 5'd7, 5'd1, 5'd2, 64'd1, 64'd2, 64'd0);
        out_ready = 1'b0;
        flush = 1'b1;
        void'(exp_q.pop_back());
        @(negedge clk);
        flush = 1'b0;
        out_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);
        end
        @(negedge clk);
        issue(OP_SUB, BEQ, 1'b0, 5'd7, 5'd1, 5'd2, 64'd9, 64'd2, 64'd0);

        // flush in the middle of a multiply
        drain();
        issue(OP_MUL, BEQ, 1'b0, 5'd8, 5'd1, 5'd2, rand_bits(64), rand_bits(64), 64'd0);
        repeat (10) @(negedge clk);
        flush = 1'b1;
        void'(exp_q.pop_back());
        @(negedge clk);
        flush = 1'b0;
        // stage is free again once the multiplier is cleared
        repeat (3) begin
            @(posedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);
            check_value("in_ready", 64'(in_ready), 64'd1);
        end
        @(negedge clk);
        issue(OP_ADD, BEQ, 1'b1, 5'd11, 5'd1, 5'd0, 64'd100, 64'd0, 64'd23);
        issue(OP_MUL, BEQ, 1'b0, 5'd12, 5'd1, 5'd2, rand_bits(64), rand_bits(64), 64'd0);
        wait_mul_out();
        drain();
        end_run();
    end

endmodule

`default_nettype wire

/* tb/ex_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_checker
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       out_valid,
    input  logic       out_ready,
    input  addr_t      out_pc,
    input  reg_idx_t   out_rd,
    input  xlen_t      out_result,
    input  logic       pc_update,
    input  logic       ex_valid,
    input  ex_op_t     ex_op,
    input  mul_state_t mul_state
);

    int fail_count = 0;

    // a MUL in execute stays hidden until its product is done
    mul_hides_output: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && (ex_op == OP_MUL) && (mul_state != MUL_DONE)) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while the multiplier is busy");
        end

    // stalled output keeps its payload
    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=>
            (out_valid && $stable(out_pc) && $stable(out_rd) && $stable(out_result)))
        else begin
            fail_count++;
            $error("output changed while stalled");
        end

    // redirect only with a transfer of a branch or jump
    redirect_on_fire: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> (out_valid && out_ready &&
            ((ex_op == OP_BRANCH) || (ex_op == OP_JAL) || (ex_op == OP_JALR))))
        else begin
            fail_count++;
            $error("pc_update without a branch or jump transfer");
        end

endmodule

bind ex_stage ex_stage_checker u_chk (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_pc(out_pc),
    .out_rd(out_rd),
    .out_result(out_result),
    .pc_update(pc_update),
    .ex_valid(ex_valid),
    .ex_op(ex_op),
    .mul_state(u_mul.state)
);

`default_nettype wire

/* source/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  addr_t    in_pc,
    input  ex_op_t   in_op,
    input  br_cond_t in_cond,
    input  logic     in_imm_sel,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  xlen_t    in_src_a,
    input  xlen_t    in_src_b,
    input  xlen_t    in_imm,
    output logic     out_valid,
    input  logic     out_ready,
    output addr_t    out_pc,
    output reg_idx_t out_rd,
    output xlen_t    out_result,
    input  logic     mem_wen,
    input  reg_idx_t mem_rd,
    input  xlen_t    mem_data,
    input  logic     wb_wen,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    output logic     pc_update,
    output addr_t    dnpc
);

    logic     ex_valid;
    addr_t    ex_pc;
    ex_op_t   ex_op;
    br_cond_t ex_cond;
    logic     ex_imm_sel;
    reg_idx_t ex_rd;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    xlen_t    ex_src_a;
    xlen_t    ex_src_b;
    xlen_t    ex_imm;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_result;
    xlen_t    mul_product;
    logic     mul_busy;
    logic     block;
    logic     out_fire;

    // stall while the multiplier works
    assign block     = (ex_op == OP_MUL) && mul_busy;
    assign in_ready  = out_ready && !block;
    assign out_valid = ex_valid && !block;
    assign out_fire  = out_valid && out_ready;

    assign out_pc     = ex_pc;
    assign out_rd     = ex_rd;
    assign out_result = (ex_op == OP_MUL) ? mul_product : alu_result;

    ex_issue_reg u_issue (
        .clk, .rst, .flush,
        .load(in_ready),
        .in_valid, .in_pc, .in_op, .in_cond, .in_imm_sel,
        .in_rd, .in_rs1, .in_rs2, .in_src_a, .in_src_b, .in_imm,
        .ex_valid, .ex_pc, .ex_op, .ex_cond, .ex_imm_sel,
        .ex_rd, .ex_rs1, .ex_rs2, .ex_src_a, .ex_src_b, .ex_imm
    );

    ex_forward u_fwd (
        .ex_rs1, .ex_rs2, .ex_src_a, .ex_src_b,
        .mem_wen, .mem_rd, .mem_data,
        .wb_wen, .wb_rd, .wb_data,
        .op_a, .op_b
    );

    ex_alu u_alu (
        .ex_op, .ex_imm_sel, .ex_pc, .op_a, .op_b, .ex_imm, .alu_result
    );

    // redirect toward fetch
    ex_branch_unit u_br (
        .ex_valid, .out_fire, .ex_op, .ex_cond, .ex_pc,
        .op_a, .op_b, .ex_imm, .pc_update, .dnpc
    );

    ex_multiplier u_mul (
        .clk, .rst, .flush, .ex_valid, .out_fire, .ex_op,
        .op_a, .op_b, .mul_busy, .mul_product
    );

endmodule

`default_nettype wire

/* source/ex_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_multiplier
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   ex_valid,
    input  logic   out_fire,
    input  ex_op_t ex_op,
    input  xlen_t  op_a,
    input  xlen_t  op_b,
    output logic   mul_busy,
    output xlen_t  mul_product
);

    mul_state_t state;
    mul_count_t count;
    xlen_t      mcand;
    xlen_t      mplier;
    xlen_t      acc;
    logic       mul_start;

    assign mul_start = ex_valid && (ex_op == OP_MUL);

    // control FSM
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (mul_start) state <= MUL_RUN;
                MUL_RUN:  if (count == mul_count_t'(`EX_MUL_STEPS - 1)) state <= MUL_DONE;
                // hold product until it is taken downstream
                MUL_DONE: if (out_fire) state <= MUL_IDLE;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    // shift-add datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (state == MUL_IDLE) begin
            mcand  <= op_a;
            mplier <= op_b;
            acc    <= '0;
            count  <= '0;
        end else if (state == MUL_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            count  <= count + 1'b1;
        end
    end

    // busy also covers the idle cycle before run starts
    assign mul_busy    = ((state == MUL_IDLE) && mul_start) || (state == MUL_RUN);
    // low half of the product only
    assign mul_product = acc;

endmodule

`default_nettype wire

/* source/ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_branch_unit
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic     ex_valid,
    input  logic     out_fire,
    input  ex_op_t   ex_op,
    input  br_cond_t ex_cond,
    input  addr_t    ex_pc,
    input  xlen_t    op_a,
    input  xlen_t    op_b,
    input  xlen_t    ex_imm,
    output logic     pc_update,
    output addr_t    dnpc
);

    logic  taken;
    logic  is_jump;
    logic  redirect;
    addr_t target;
    addr_t jalr_sum;

    // condition on forwarded operands
    always_comb begin
        case (ex_cond)
            BEQ:     taken = (op_a == op_b);
            BNE:     taken = (op_a != op_b);
            BLT:     taken = ($signed(op_a) < $signed(op_b));
            BGE:     taken = ($signed(op_a) >= $signed(op_b));
            BLTU:    taken = (op_a < op_b);
            BGEU:    taken = (op_a >= op_b);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump  = (ex_op == OP_JAL) || (ex_op == OP_JALR);
    assign redirect = is_jump || ((ex_op == OP_BRANCH) && taken);

    // jalr target has bit 0 cleared
    assign jalr_sum = op_a + ex_imm;
    assign target   = (ex_op == OP_JALR) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : ex_pc + ex_imm;

    // redirect fetch only when the instruction leaves the stage
    assign pc_update = ex_valid && out_fire && redirect;
    assign dnpc      = redirect ? target : ex_pc + addr_t'(`EX_INST_BYTES);

endmodule

`default_nettype wire

/* source/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  ex_op_t ex_op,
    input  logic   ex_imm_sel,
    input  addr_t  ex_pc,
    input  xlen_t  op_a,
    input  xlen_t  op_b,
    input  xlen_t  ex_imm,
    output xlen_t  alu_result
);

    xlen_t       src_b;
    xlen_t       sum;
    logic [5:0]  shamt;
    addr_t       link;

    // immediate forms take imm as second operand
    assign src_b = ex_imm_sel ? ex_imm : op_b;
    assign sum   = op_a + src_b;
    // rv64 shifts use six amount bits
    assign shamt = src_b[5:0];
    assign link  = ex_pc + addr_t'(`EX_INST_BYTES);

    always_comb begin
        case (ex_op)
            OP_ADD:   alu_result = sum;
            OP_SUB:   alu_result = op_a - src_b;
            OP_AND:   alu_result = op_a & src_b;
            OP_OR:    alu_result = op_a | src_b;
            OP_XOR:   alu_result = op_a ^ src_b;
            OP_SLL:   alu_result = op_a << shamt;
            OP_SRL:   alu_result = op_a >> shamt;
            OP_SRA:   alu_result = xlen_t'($signed(op_a) >>> shamt);
            OP_SLT:   alu_result = xlen_t'($signed(op_a) < $signed(src_b));
            OP_SLTU:  alu_result = xlen_t'(op_a < src_b);
            // word add, sign extend low half
            OP_ADDW:  alu_result = {{32{sum[31]}}, sum[31:0]};
            OP_LUI:   alu_result = ex_imm;
            OP_AUIPC: alu_result = ex_pc + ex_imm;
            // link value for jumps
            OP_JAL:   alu_result = link;
            OP_JALR:  alu_result = link;
            // mul and branch results come from elsewhere
            default:  alu_result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* source/ex_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_forward
    import ex_data_pkg::*;
(
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  xlen_t    ex_src_a,
    input  xlen_t    ex_src_b,
    input  logic     mem_wen,
    input  reg_idx_t mem_rd,
    input  xlen_t    mem_data,
    input  logic     wb_wen,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    output xlen_t    op_a,
    output xlen_t    op_b
);

    // youngest producer first: MEM, then WB, then register file
    function automatic xlen_t pick(input reg_idx_t idx, input xlen_t rf_val);
        logic hit_mem;
        logic hit_wb;
        hit_mem = mem_wen && (mem_rd == idx) && (idx != '0);
        hit_wb  = wb_wen && (wb_rd == idx) && (idx != '0);
        if (hit_mem) begin
            return mem_data;
        end else if (hit_wb) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign op_a = pick(ex_rs1, ex_src_a);
    assign op_b = pick(ex_rs2, ex_src_b);

endmodule

`default_nettype wire

/* source/ex_issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     load,
    input  logic     in_valid,
    input  addr_t    in_pc,
    input  ex_op_t   in_op,
    input  br_cond_t in_cond,
    input  logic     in_imm_sel,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  xlen_t    in_src_a,
    input  xlen_t    in_src_b,
    input  xlen_t    in_imm,
    output logic     ex_valid,
    output addr_t    ex_pc,
    output ex_op_t   ex_op,
    output br_cond_t ex_cond,
    output logic     ex_imm_sel,
    output reg_idx_t ex_rd,
    output reg_idx_t ex_rs1,
    output reg_idx_t ex_rs2,
    output xlen_t    ex_src_a,
    output xlen_t    ex_src_b,
    output xlen_t    ex_imm
);

    // valid bit, flush wins over a load in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_valid <= 1'b0;
        end else if (load) begin
            ex_valid <= in_valid;
        end
    end

    // payload only follows load
    always_ff @(posedge clk) begin
        if (load) begin
            ex_pc      <= in_pc;
            ex_op      <= in_op;
            ex_cond    <= in_cond;
            ex_imm_sel <= in_imm_sel;
            ex_rd      <= in_rd;
            ex_rs1     <= in_rs1;
            ex_rs2     <= in_rs2;
            ex_src_a   <= in_src_a;
            ex_src_b   <= in_src_b;
            ex_imm     <= in_imm;
        end
    end

endmodule

`default_nettype wire

/* source/ex_op_pkg.sv */
`default_nettype none

package ex_op_pkg;

    // decoded execute operation
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDW, OP_LUI, OP_AUIPC, OP_MUL,
        OP_BRANCH, OP_JAL, OP_JALR
    } ex_op_t;

    // branch condition, funct3 encoding
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_cond_t;

    // iterative multiplier FSM
    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_t;

endpackage

`default_nettype wire

/* source/ex_data_pkg.sv */
`default_nettype none

`include "ex_consts.svh"

package ex_data_pkg;

    // data word as it moves through execute
    typedef logic [`EX_XLEN-1:0] xlen_t;

    // program counter
    typedef logic [`EX_XLEN-1:0] addr_t;

    // register index
    typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;

    // multiplier step counter, wide enough for EX_MUL_STEPS
    typedef logic [$clog2(`EX_MUL_STEPS+1)-1:0] mul_count_t;

endpackage

`default_nettype wire

/* source/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath width of the core
`define EX_XLEN 64

// architectural register index
`define EX_REG_IDX_W 5

// one shift-add step per multiplier bit
`define EX_MUL_STEPS `EX_XLEN

// fall-through pc step, no compressed instructions
`define EX_INST_BYTES 4

`endif
